// File: logic/axi_rd_settings.svh
/*
 * Width and latency settings for the AXI read subordinate.
 * Include this header wherever a width or the component latency is needed.
 */
`ifndef AXI_RD_SETTINGS_SVH
`define AXI_RD_SETTINGS_SVH

// Address width in bits
`define AXI_RD_AW 32

// Data width in bits (four bytes per word)
`define AXI_RD_DW 32

// Transaction ID width
`define AXI_RD_IW 4

// Cycles from a counted component access to valid read data
`define AXI_RD_C_LAT 1

// One skid stage per beat that can be in flight plus one for the stall
`define AXI_RD_NSTAGE (`AXI_RD_C_LAT + 1)

`endif

// File: logic/axi_proto_pkg.sv
/*
 * AXI protocol encodings used on the AR and R channels.
 * Import wherever burst types or response codes are decoded or produced.
 */
`default_nettype none

package axi_proto_pkg;

    // --------------------
    // Burst type (ARBURST)
    // --------------------
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // --------------------
    // Read response (RRESP)
    // --------------------
    // Exclusive access is not supported so EXOKAY never appears
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

`default_nettype wire

// File: logic/rd_pipe_pkg.sv
/*
 * Types for the beats carried through the read return pipeline.
 * Import where a beat or its context is stored or passed between stages.
 */
`default_nettype none

`include "axi_rd_settings.svh"

package rd_pipe_pkg;

    // Per-beat context that travels beside the read data
    typedef struct packed {
        logic [`AXI_RD_IW-1:0] id;
        // RRESP encoding
        logic [1:0]            resp;
        logic                  last;
    } beat_ctx_t;

    // Full R channel payload of one beat
    typedef struct packed {
        logic [`AXI_RD_DW-1:0] data;
        beat_ctx_t             ctx;
    } beat_t;

endpackage

`default_nettype wire

// File: logic/rd_stage_if.sv
/*
 * One link of the read return pipeline with a valid/ready handshake.
 * The producer takes the src modport and the consumer takes dst.
 */
`timescale 1ns/100ps
`default_nettype none

interface rd_stage_if import rd_pipe_pkg::*; ();

    // Beat offered by the producer
    logic  valid;
    // Consumer can take the beat this cycle
    logic  ready;
    // Data, ID, response and last
    beat_t beat;

    // Producer side
    modport src (
        output valid,
        output beat,
        input  ready
    );

    // Consumer side
    modport dst (
        input  valid,
        input  beat,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/rd_burst_addr.sv
/*
 * Next-beat address for FIXED, INCR and WRAP read bursts.
 * Purely combinational and fed with the full byte address of the current beat.
 */
`timescale 1ns/100ps
`default_nettype none

`include "axi_rd_settings.svh"

module rd_burst_addr import axi_proto_pkg::*; (
    input  wire logic [`AXI_RD_AW-1:0] i_addr,
    input  wire logic [2:0]            i_size,
    input  wire axi_burst_e            i_burst,
    input  wire logic [7:0]            i_len,
    output logic      [`AXI_RD_AW-1:0] o_next_addr
);

    localparam int AW = `AXI_RD_AW;

    // Bytes per beat
    logic [AW-1:0] size_bytes;
    // Address aligned down to the transfer size
    logic [AW-1:0] aligned;
    logic [AW-1:0] incr_addr;
    // Low bits that change inside the wrap window
    logic [AW-1:0] wrap_mask;

    always_comb begin
        size_bytes = AW'(1) << i_size;
        aligned    = i_addr & ~(size_bytes - AW'(1));
        incr_addr  = aligned + size_bytes;
        // Window is (len+1) beats, a power of two for legal WRAP bursts
        wrap_mask  = ((AW'(i_len) + AW'(1)) << i_size) - AW'(1);
    end

    // --------------------
    // Burst type select
    // --------------------
    always_comb begin
        case (i_burst)
            AXI_BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            AXI_BURST_WRAP: begin
                // Upper bits stay at the window base
                o_next_addr = (i_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            end
            // FIXED and the reserved code repeat the address
            default: begin
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rd_req_issue.sv
/*
 * Accepts AR bursts and issues one component access per beat.
 * Tracks beat context through the component latency and drives link 0.
 */
`timescale 1ns/100ps
`default_nettype none

`include "axi_rd_settings.svh"

module rd_req_issue import axi_proto_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // AR channel
    input  wire logic                  i_arvalid,
    input  wire logic [`AXI_RD_AW-1:0] i_araddr,
    input  wire logic [1:0]            i_arburst,
    input  wire logic [2:0]            i_arsize,
    input  wire logic [7:0]            i_arlen,
    input  wire logic [`AXI_RD_IW-1:0] i_arid,
    output logic                       o_arready,
    // Component request side
    output logic                       o_dv,
    output logic      [`AXI_RD_AW-1:0] o_addr,
    output logic      [`AXI_RD_IW-1:0] o_id,
    output logic                       o_last,
    input  wire logic                  i_hld,
    input  wire logic                  i_err,
    input  wire logic [`AXI_RD_DW-1:0] i_rdata,
    // Room in the final skid stage
    input  wire logic                  i_space,
    rd_stage_if.src                    o_beat
);

    localparam int AW    = `AXI_RD_AW;
    localparam int IW    = `AXI_RD_IW;
    localparam int C_LAT = `AXI_RD_C_LAT;
    // Byte offset bits inside one data word
    localparam int BW    = $clog2(`AXI_RD_DW / 8);

    // --------------------
    // Burst tracking
    // --------------------
    logic          active;
    // Beats left after the current one
    logic [7:0]    beat_cnt;
    logic [AW-1:0] burst_addr;
    axi_burst_e    burst_type;
    logic [2:0]    burst_size;
    logic [7:0]    burst_len;
    logic [IW-1:0] burst_id;
    logic [AW-1:0] next_addr;

    logic accept;
    logic access;
    logic final_access;

    always_comb begin
        o_dv         = active && i_space;
        access       = o_dv && !i_hld;
        final_access = access && (beat_cnt == 8'd0);
        // New burst allowed once the old one has issued its last access
        o_arready    = !active || final_access;
        accept       = i_arvalid && o_arready;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            beat_cnt <= 8'd0;
        end else if (accept) begin
            active   <= 1'b1;
            beat_cnt <= i_arlen;
        end else if (access) begin
            active   <= !final_access;
            // Hold at zero after the final beat
            if (beat_cnt != 8'd0) begin
                beat_cnt <= beat_cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            burst_addr <= i_araddr;
            burst_type <= axi_burst_e'(i_arburst);
            burst_size <= i_arsize;
            burst_len  <= i_arlen;
            burst_id   <= i_arid;
        end else if (access) begin
            burst_addr <= next_addr;
        end
    end

    // Full byte address keeps narrow bursts stepping correctly
    rd_burst_addr rd_burst_addr_i (
        .i_addr      (burst_addr),
        .i_size      (burst_size),
        .i_burst     (burst_type),
        .i_len       (burst_len),
        .o_next_addr (next_addr)
    );

    // Component only sees whole words
    always_comb begin
        o_addr = {burst_addr[AW-1:BW], {BW{1'b0}}};
        o_id   = burst_id;
        o_last = active && (beat_cnt == 8'd0);
    end

    // --------------------
    // Latency pipeline
    // --------------------
    // Index 0 is the access of this cycle, index C_LAT meets i_rdata
    logic [C_LAT:0]         lat_vld;
    logic [C_LAT:0]         lat_last;
    logic [C_LAT:0][IW-1:0] lat_id;

    always_comb begin
        lat_vld[0]  = access;
        lat_last[0] = o_last;
        lat_id[0]   = burst_id;
    end

    generate
        if (C_LAT > 0) begin : g_lat
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    lat_vld[C_LAT:1] <= '0;
                end else begin
                    lat_vld[C_LAT:1] <= lat_vld[C_LAT-1:0];
                end
            end

            // Context only matters where the matching valid bit is set
            always_ff @(posedge clk) begin
                lat_last[C_LAT:1] <= lat_last[C_LAT-1:0];
                lat_id[C_LAT:1]   <= lat_id[C_LAT-1:0];
            end
        end
    endgenerate

    // Merge returned data and error with the delayed context
    always_comb begin
        o_beat.valid         = lat_vld[C_LAT];
        o_beat.beat.data     = i_rdata;
        o_beat.beat.ctx.id   = lat_id[C_LAT];
        o_beat.beat.ctx.resp = i_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        o_beat.beat.ctx.last = lat_last[C_LAT];
    end

endmodule

`default_nettype wire

// File: logic/rd_skid_stage.sv
/*
 * One skid buffer stage of the read return path.
 * Passes beats straight through when empty and parks one beat on a stall.
 */
`timescale 1ns/100ps
`default_nettype none

module rd_skid_stage import rd_pipe_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    // Upstream link
    rd_stage_if.dst   i_up,
    // Downstream link
    rd_stage_if.src   o_dn
);

    // --------------------
    // Held entry
    // --------------------
    logic  held_vld;
    beat_t held_beat;

    // Beat arrives while the output cannot move it on
    logic  capture;

    always_comb begin
        capture = i_up.valid && !held_vld && !o_dn.ready;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_vld <= 1'b0;
        end else if (capture) begin
            held_vld <= 1'b1;
        end else if (o_dn.ready) begin
            // Parked beat leaves this cycle
            held_vld <= 1'b0;
        end
    end

    // Payload follows held_vld
    always_ff @(posedge clk) begin
        if (capture) begin
            held_beat <= i_up.beat;
        end
    end

    // --------------------
    // Handshake
    // --------------------
    // Room exists only while nothing is parked
    always_comb begin
        i_up.ready = !held_vld;
    end

    // Parked beat goes first so order is kept
    always_comb begin
        o_dn.valid = held_vld || i_up.valid;
        if (held_vld) begin
            o_dn.beat = held_beat;
        end else begin
            o_dn.beat = i_up.beat;
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_rd_sub.sv
/*
 * AXI read subordinate top level with plain AR/R and component ports.
 * Joins the request issuer to a chain of skid stages ending on the R channel.
 */
`timescale 1ns/100ps
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_sub (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // AR channel
    input  wire logic                  i_arvalid,
    input  wire logic [`AXI_RD_AW-1:0] i_araddr,
    input  wire logic [1:0]            i_arburst,
    input  wire logic [2:0]            i_arsize,
    input  wire logic [7:0]            i_arlen,
    input  wire logic [`AXI_RD_IW-1:0] i_arid,
    output logic                       o_arready,
    // R channel
    output logic                       o_rvalid,
    output logic      [`AXI_RD_DW-1:0] o_rdata,
    output logic      [`AXI_RD_IW-1:0] o_rid,
    output logic      [1:0]            o_rresp,
    output logic                       o_rlast,
    input  wire logic                  i_rready,
    // Component interface
    output logic                       o_dv,
    output logic      [`AXI_RD_AW-1:0] o_addr,
    output logic      [`AXI_RD_IW-1:0] o_id,
    output logic                       o_last,
    input  wire logic                  i_hld,
    input  wire logic                  i_err,
    input  wire logic [`AXI_RD_DW-1:0] i_rdata
);

    localparam int NSTAGE = `AXI_RD_NSTAGE;

    // Link k feeds stage k and the last link reaches the R ports
    rd_stage_if link [0:NSTAGE] ();

    rd_req_issue rd_req_issue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_arvalid (i_arvalid),
        .i_araddr  (i_araddr),
        .i_arburst (i_arburst),
        .i_arsize  (i_arsize),
        .i_arlen   (i_arlen),
        .i_arid    (i_arid),
        .o_arready (o_arready),
        .o_dv      (o_dv),
        .o_addr    (o_addr),
        .o_id      (o_id),
        .o_last    (o_last),
        .i_hld     (i_hld),
        .i_err     (i_err),
        .i_rdata   (i_rdata),
        // Final stage is first to fill under back-pressure
        .i_space   (link[NSTAGE-1].ready),
        .o_beat    (link[0])
    );

    // --------------------
    // Return pipeline
    // --------------------
    generate
        for (genvar k = 0; k < NSTAGE; k++) begin : g_stage
            rd_skid_stage rd_skid_stage_i (
                .clk   (clk),
                .rst_n (rst_n),
                .i_up  (link[k]),
                .o_dn  (link[k+1])
            );
        end
    endgenerate

    // Last link straight onto the R ports
    assign link[NSTAGE].ready = i_rready;
    assign o_rvalid = link[NSTAGE].valid;
    assign o_rdata  = link[NSTAGE].beat.data;
    assign o_rid    = link[NSTAGE].beat.ctx.id;
    assign o_rresp  = link[NSTAGE].beat.ctx.resp;
    assign o_rlast  = link[NSTAGE].beat.ctx.last;

endmodule

`default_nettype wire

// File: sim/axi_rd_sub_tb.sv
/*
 * Testbench for the AXI read subordinate with a component model and an R checker.
 * Random bursts are compared beat by beat with a reference address model.
 */
`timescale 1ns/100ps
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_sub_tb import axi_proto_pkg::*; ();

    localparam int AW    = `AXI_RD_AW;
    localparam int DW    = `AXI_RD_DW;
    localparam int IW    = `AXI_RD_IW;
    localparam int C_LAT = `AXI_RD_C_LAT;
    // Depth of the component model pipe, at least one entry
    localparam int LAT_D = (C_LAT > 0) ? C_LAT : 1;
    localparam logic [DW-1:0] DATA_KEY = 32'h5a3c_96e1;
    // Component error window on word addresses
    localparam logic [AW-1:0] ERR_LO = 32'h0000_1400;
    localparam logic [AW-1:0] ERR_HI = 32'h0000_1480;
    // Bursts per test
    localparam int NB_INCR   = 20;
    localparam int NB_NARROW = 30;
    localparam int NB_ERR    = 12;
    localparam int NB_RAND   = 60;
    // Up to 16 beats per burst and 40 cycles per beat
    localparam int WATCHDOG_CYCLES = (NB_INCR + NB_NARROW + NB_ERR + NB_RAND) * 16 * 40 + 200;

    logic clk, rst_n;
    logic i_arvalid, o_arready;
    logic [AW-1:0] i_araddr;
    logic [1:0] i_arburst;
    logic [2:0] i_arsize;
    logic [7:0] i_arlen;
    logic [IW-1:0] i_arid;
    logic o_rvalid, o_rlast, i_rready;
    logic [DW-1:0] o_rdata;
    logic [IW-1:0] o_rid;
    logic [1:0] o_rresp;
    logic o_dv, o_last, i_hld, i_err;
    logic [AW-1:0] o_addr;
    logic [IW-1:0] o_id;
    logic [DW-1:0] i_rdata;

    typedef struct packed {
        logic [DW-1:0] data;
        logic [IW-1:0] id;
        logic [1:0]    resp;
        logic          last;
    } exp_beat_t;

    // Expected component request of one counted access
    typedef struct packed {
        logic [AW-1:0] addr;
        logic [IW-1:0] id;
        logic          last;
    } exp_acc_t;

    exp_beat_t     r_q[$];
    exp_acc_t      acc_q[$];
    logic [31:0]   lcg_state = 32'hd1bb;
    logic          bp_en = 1'b0;
    int            errors = 0;
    int            checks = 0;
    // Counted accesses and beats of accepted bursts
    int            issued = 0;
    int            accepted_beats = 0;

    axi_rd_sub axi_rd_sub_i (
        .clk(clk), .rst_n(rst_n),
        .i_arvalid(i_arvalid), .i_araddr(i_araddr), .i_arburst(i_arburst),
        .i_arsize(i_arsize), .i_arlen(i_arlen), .i_arid(i_arid), .o_arready(o_arready),
        .o_rvalid(o_rvalid), .o_rdata(o_rdata), .o_rid(o_rid), .o_rresp(o_rresp),
        .o_rlast(o_rlast), .i_rready(i_rready),
        .o_dv(o_dv), .o_addr(o_addr), .o_id(o_id), .o_last(o_last),
        .i_hld(i_hld), .i_err(i_err), .i_rdata(i_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // Low LCG bits repeat quickly
        return lcg_state >> 8;
    endfunction

    function automatic logic in_err_window(input logic [AW-1:0] addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    // Word address of beat n, straight from the AXI burst rules
    function automatic logic [AW-1:0] beat_addr(input logic [AW-1:0] start,
            input logic [1:0] burst, input logic [2:0] size, input logic [7:0] len,
            input int n);
        logic [AW-1:0] nbytes, base, window, lo, addr;
        nbytes = 32'd1 << size;
        base   = start - (start % nbytes);
        window = nbytes * (32'(len) + 32'd1);
        lo     = start - (start % window);
        if (burst == AXI_BURST_FIXED || n == 0) begin
            addr = start;
        end else if (burst == AXI_BURST_INCR) begin
            addr = base + 32'(n) * nbytes;
        end else begin
            addr = lo + ((base - lo + 32'(n) * nbytes) % window);
        end
        return addr & ~32'h3;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
            input logic [31:0] exp);
        $display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic print_result(input int num, input string name, input int n_err);
        if (n_err == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, n_err);
        end
    endtask

    // --------------------
    // Component model
    // --------------------
    logic [AW-1:0] comp_addr_q [1:LAT_D];
    logic [AW-1:0] ret_addr;

    initial begin : comp_model
        logic [AW-1:0] addr_at_edge;
        for (int k = 1; k <= LAT_D; k++) begin
            comp_addr_q[k] = '0;
        end
        forever begin
            @(posedge clk);
            addr_at_edge = o_addr;
            #1;
            for (int k = LAT_D; k > 1; k--) begin
                comp_addr_q[k] = comp_addr_q[k-1];
            end
            comp_addr_q[1] = addr_at_edge;
        end
    end

    assign ret_addr = (C_LAT == 0) ? o_addr : comp_addr_q[LAT_D];
    assign i_rdata  = ret_addr ^ DATA_KEY;
    assign i_err    = in_err_window(ret_addr);

    // --------------------
    // Stimulus
    // --------------------
    // One cycle, AR accept seen at the edge, new inputs 1 ns later
    task automatic step(output logic acc);
        @(posedge clk);
        acc = i_arvalid && o_arready;
        #1;
        if (bp_en) begin
            i_hld    = (rand32() % 100) < 25;
            i_rready = (rand32() % 100) >= 30;
        end else begin
            i_hld    = 1'b0;
            i_rready = 1'b1;
        end
    endtask

    // Mode 0 INCR words, 1 WRAP/FIXED narrow, 2 error window, 3 anything
    task automatic gen_burst(input int mode);
        logic [2:0]    size;
        logic [7:0]    len;
        logic [1:0]    burst;
        logic [AW-1:0] addr;
        size  = 3'd2;
        burst = AXI_BURST_INCR;
        addr  = rand32() & 32'h0000_1fff;
        len   = 8'(rand32() % 16);
        case (mode)
            1: begin
                burst = (rand32() % 2 == 0) ? AXI_BURST_WRAP : AXI_BURST_FIXED;
                size  = 3'(rand32() % 3);
            end
            2: addr = ERR_LO - 32'h40 + ((rand32() % 64) << 2);
            3: begin
                burst = 2'(rand32() % 3);
                size  = 3'(rand32() % 3);
            end
            default: ;
        endcase
        // WRAP needs 2, 4, 8 or 16 beats
        if (burst == AXI_BURST_WRAP) len = (8'd2 << (rand32() % 4)) - 8'd1;
        if (mode != 3 && burst != AXI_BURST_FIXED) addr = addr & ~((32'd1 << size) - 32'd1);
        i_araddr  = addr;
        i_arburst = burst;
        i_arsize  = size;
        i_arlen   = len;
        i_arid    = 4'(rand32());
    endtask

    task automatic issue_burst();
        logic [AW-1:0] a;
        exp_beat_t     e;
        exp_acc_t      x;
        logic          acc;
        for (int n = 0; n <= int'(i_arlen); n++) begin
            a = beat_addr(i_araddr, i_arburst, i_arsize, i_arlen, n);
            x.addr = a;
            x.id   = i_arid;
            x.last = (n == int'(i_arlen));
            acc_q.push_back(x);
            e.data = a ^ DATA_KEY;
            e.id   = i_arid;
            e.resp = in_err_window(a) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            e.last = (n == int'(i_arlen));
            r_q.push_back(e);
        end
        i_arvalid = 1'b1;
        acc = 1'b0;
        while (!acc) step(acc);
        i_arvalid = 1'b0;
    endtask

    task automatic run_test(input int num, input string name, input int mode,
            input int nbursts, input logic bp);
        int   err_start;
        logic acc;
        err_start = errors;
        bp_en = bp;
        for (int b = 0; b < nbursts; b++) begin
            gen_burst(mode);
            issue_burst();
        end
        while (r_q.size() != 0) step(acc);
        // Idle cycles expose any extra beat
        repeat (4) step(acc);
        print_result(num, name, errors - err_start);
    endtask

    task automatic check_idle();
        int err_start;
        err_start = errors;
        repeat (3) begin
            @(posedge clk);
            checks++;
            assert (!o_rvalid && !o_dv && o_arready) else begin
                $display("FAIL t=%0t rvalid/dv/arready got %b%b%b expected 001",
                         $time, o_rvalid, o_dv, o_arready);
                errors++;
            end
            #1;
        end
        print_result(1, "idle after reset", errors - err_start);
    endtask

    // --------------------
    // Checker
    // --------------------
    always @(posedge clk) begin : r_check
        exp_acc_t  exp_a;
        exp_beat_t exp_b;
        if (rst_n) begin
            // One expected address, ID and last per counted access
            if (o_dv && !i_hld) begin
                issued++;
                if (acc_q.size() == 0) begin
                    $display("error at %0t: component access with no burst outstanding", $time);
                    errors++;
                end else begin
                    exp_a = acc_q.pop_front();
                    checks++;
                    assert (o_addr == exp_a.addr)
                        else report_mismatch("o_addr", o_addr, exp_a.addr);
                    assert (o_id == exp_a.id)
                        else report_mismatch("o_id", 32'(o_id), 32'(exp_a.id));
                    assert (o_last == exp_a.last)
                        else report_mismatch("o_last", 32'(o_last), 32'(exp_a.last));
                end
            end
            if (i_arvalid && o_arready) begin
                checks++;
                assert (issued == accepted_beats) else begin
                    $display("error at %0t: %s", $time,
                             "AR accepted while the previous burst had accesses left");
                    errors++;
                end
                accepted_beats += int'(i_arlen) + 1;
            end
            if (o_rvalid && i_rready) begin
                if (r_q.size() == 0) begin
                    $display("error at %0t: R beat returned with none expected", $time);
                    errors++;
                end else begin
                    exp_b = r_q.pop_front();
                    checks++;
                    assert (o_rdata == exp_b.data)
                        else report_mismatch("o_rdata", o_rdata, exp_b.data);
                    assert (o_rid == exp_b.id)
                        else report_mismatch("o_rid", 32'(o_rid), 32'(exp_b.id));
                    assert (o_rresp == exp_b.resp)
                        else report_mismatch("o_rresp", 32'(o_rresp), 32'(exp_b.resp));
                    assert (o_rlast == exp_b.last)
                        else report_mismatch("o_rlast", 32'(o_rlast), 32'(exp_b.last));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        rst_n     = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arburst = '0;
        i_arsize  = '0;
        i_arlen   = '0;
        i_arid    = '0;
        i_rready  = 1'b0;
        i_hld     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        i_rready = 1'b1;
        check_idle();
        run_test(2, "incr full width", 0, NB_INCR, 1'b0);
        run_test(3, "wrap and fixed narrow", 1, NB_NARROW, 1'b0);
        run_test(4, "error window", 2, NB_ERR, 1'b0);
        run_test(5, "random back-pressure", 3, NB_RAND, 1'b1);
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: axi_rd_sub.f
+incdir+logic
logic/axi_proto_pkg.sv
logic/rd_pipe_pkg.sv
logic/rd_stage_if.sv
logic/rd_burst_addr.sv
logic/rd_req_issue.sv
logic/rd_skid_stage.sv
logic/axi_rd_sub.sv
sim/axi_rd_sub_tb.sv

// File: Makefile
# Verilator build and run of the AXI read subordinate testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= axi_rd_sub_tb
FILELIST  ?= axi_rd_sub.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code does not
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
